/* Makefile */
# Verilator build, run and lint for the e^x project

VERILATOR  ?= verilator
TOP        ?= tb_fp_exp
RTL_TOP    ?= fp_exp_top
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the simulator's exit status is the pass or fail of the run
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/exp_series_pkg.sv */
package exp_series_pkg;

    import fp_types_pkg::*;

    // 1.0, first term of the series and dividend of the reciprocal
    localparam fp_word_t FP_ONE = 32'h3F80_0000;

    // factorial divisors, indexed by the power of x
    // all exactly representable in single precision
    localparam fp_word_t FACT_TABLE [2:7] = '{
        // 2! = 2.0
        32'h4000_0000,
        // 3! = 6.0
        32'h40C0_0000,
        // 4! = 24.0
        32'h41C0_0000,
        // 5! = 120.0
        32'h42F0_0000,
        // 6! = 720.0
        32'h4434_0000,
        // 7! = 5040.0
        32'h459D_8000
    };

endpackage

/* hdl/exp_taylor.sv */
`timescale 1ns/1ps
`include "fp_cfg.svh"

module exp_taylor import fp_types_pkg::*, exp_series_pkg::*; (
    input  fp_word_t x_value,
    output fp_word_t result
);

    localparam int N = `EXP_TERMS;

    fp_fields_t x_fields;
    fp_word_t   x_abs;
    // power[k] = |x|^k
    fp_word_t   power   [1:N];
    // term[k] = |x|^k / k!
    fp_word_t   term    [2:N];
    // partial[k] = 1 + |x| + ... + term[k]
    fp_word_t   partial [1:N];
    fp_word_t   recip;

    assign x_fields = x_value;

    // series runs on the magnitude only
    assign x_abs    = {1'b0, x_fields.exponent, x_fields.mantissa};
    assign power[1] = x_abs;

    // first two terms of the series
    fp_add u_add_first (
        .a   (FP_ONE),
        .b   (x_abs),
        .sum (partial[1])
    );

    // one multiply, divide and add per higher power
    for (genvar k = 2; k <= N; k++) begin : g_term
        fp_mul u_mul (
            .a       (power[k-1]),
            .b       (x_abs),
            .product (power[k])
        );

        fp_div u_div (
            .a        (power[k]),
            .b        (FACT_TABLE[k]),
            .quotient (term[k])
        );

        fp_add u_add (
            .a   (partial[k-1]),
            .b   (term[k]),
            .sum (partial[k])
        );
    end

    // e^-|x| = 1 / e^|x|
    fp_div u_recip (
        .a        (FP_ONE),
        .b        (partial[N]),
        .quotient (recip)
    );

    // input sign picks the folded result, -0 also takes the reciprocal
    assign result = x_fields.sign ? recip : partial[N];

endmodule

/* hdl/fp_add.sv */
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_add import fp_types_pkg::*; (
    input  fp_word_t a,
    input  fp_word_t b,
    output fp_word_t sum
);

    localparam int MW  = `FP_MAN_BITS;
    localparam int EW  = `FP_EXP_BITS;
    // guard bits kept below the mantissa through alignment
    localparam int GW  = 3;
    // carry + hidden bit + mantissa + guard
    localparam int SW  = MW + GW + 2;
    localparam int LZW = $clog2(SW);

    fp_fields_t     fa;
    fp_fields_t     fb;
    fp_fields_t     big;
    fp_fields_t     small_op;
    fp_fields_t     res;
    logic [EW-1:0]  exp_diff;
    logic [SW-1:0]  big_ext;
    logic [SW-1:0]  small_ext;
    logic [SW-1:0]  small_aligned;
    logic [SW-1:0]  raw_sum;
    logic [SW-1:0]  norm_sum;
    logic [LZW-1:0] lead_zeros;
    fp_exp_wide_t   exp_norm;

    assign fa = a;
    assign fb = b;

    // larger magnitude first
    // exponent and mantissa compare as one unsigned number
    // so the subtract path below never goes negative
    always_comb begin
        if ({fa.exponent, fa.mantissa} >= {fb.exponent, fb.mantissa}) begin
            big      = fa;
            small_op = fb;
        end else begin
            big      = fb;
            small_op = fa;
        end
    end

    // hidden bit restored for normal operands
    // zero exponent flushes a denormal to zero
    assign big_ext = (big.exponent == '0) ? '0 :
                     {2'b01, big.mantissa, {GW{1'b0}}};
    assign small_ext = (small_op.exponent == '0) ? '0 :
                       {2'b01, small_op.mantissa, {GW{1'b0}}};

    // align smaller operand
    // bits past the guard are dropped
    assign exp_diff      = big.exponent - small_op.exponent;
    assign small_aligned = small_ext >> exp_diff;

    // effective add or subtract on the signs
    assign raw_sum = (big.sign == small_op.sign) ? big_ext + small_aligned :
                                                   big_ext - small_aligned;

    // leading-zero search
    // scan from the lsb up
    // last set bit seen is the leading one
    always_comb begin
        lead_zeros = '0;
        for (int i = 0; i < SW; i++) begin
            if (raw_sum[i]) begin
                lead_zeros = LZW'(SW - 1 - i);
            end
        end
    end

    // leading one moves to the msb
    // mantissa sits right below it
    assign norm_sum = raw_sum << lead_zeros;

    // +1 since the hidden bit nominally sits one below the carry bit
    assign exp_norm = fp_exp_wide_t'(big.exponent) + fp_exp_wide_t'(1)
                    - fp_exp_wide_t'(lead_zeros);

    always_comb begin
        res.sign     = big.sign;
        res.exponent = exp_norm[EW-1:0];
        // truncation drops the guard bits
        res.mantissa = norm_sum[SW-2 -: MW];
        if (raw_sum == '0) begin
            // exact cancellation gives +0
            res.sign     = 1'b0;
            res.exponent = '0;
            res.mantissa = '0;
        end else if (exp_norm <= 0) begin
            // underflow flushed to a signed zero
            res.exponent = '0;
            res.mantissa = '0;
        end else if (exp_norm >= fp_exp_wide_t'(FP_EXP_MAX)) begin
            // overflow saturates to infinity
            res.exponent = FP_EXP_MAX;
            res.mantissa = '0;
        end
    end

    assign sum = res;

endmodule

/* hdl/fp_cfg.svh */
`ifndef FP_CFG_SVH
`define FP_CFG_SVH

// float field widths, single precision by default

// biased exponent field
`define FP_EXP_BITS 8

// stored mantissa, hidden bit not counted
`define FP_MAN_BITS 23

// sign bit + exponent + mantissa
`define FP_WIDTH (1 + `FP_EXP_BITS + `FP_MAN_BITS)

// highest power of x in the taylor series
// supported range 2 to 7, limited by the factorial table
`define EXP_TERMS 5

`endif

/* hdl/fp_div.sv */
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_div import fp_types_pkg::*; (
    input  fp_word_t a,
    input  fp_word_t b,
    output fp_word_t quotient
);

    localparam int MW = `FP_MAN_BITS;
    // one integer bit + mantissa + one spare for the normalise shift
    localparam int QW = MW + 2;

    fp_fields_t    fa;
    fp_fields_t    fb;
    fp_fields_t    res;
    logic [MW:0]   ma;
    logic [MW:0]   mb;
    logic [MW+1:0] rem;
    logic [MW+2:0] trial;
    logic [QW-1:0] quo;
    logic [MW-1:0] man_norm;
    fp_exp_wide_t  exp_diff;
    fp_exp_wide_t  exp_norm;
    logic          a_zero;
    logic          b_zero;

    assign fa = a;
    assign fb = b;

    // denormals flushed, only the exponent decides
    assign a_zero = (fa.exponent == '0);
    assign b_zero = (fb.exponent == '0);

    assign ma = {1'b1, fa.mantissa};
    assign mb = {1'b1, fb.mantissa};

    // restoring division, one quotient bit per step, msb first
    // quo[QW-1] has weight 1, ratio of the mantissas is in (0.5, 2)
    always_comb begin
        rem = {1'b0, ma};
        quo = '0;
        for (int i = QW - 1; i >= 0; i--) begin
            trial = {1'b0, rem} - {2'b00, mb};
            // borrow out means the trial failed, old remainder kept
            if (!trial[MW+2]) begin
                rem    = trial[MW+1:0];
                quo[i] = 1'b1;
            end
            rem = rem << 1;
        end
    end

    // bias added back after the subtract
    assign exp_diff = fp_exp_wide_t'(fa.exponent) - fp_exp_wide_t'(fb.exponent)
                    + fp_exp_wide_t'(FP_BIAS);

    // ratio below one needs a one bit left shift
    always_comb begin
        if (quo[QW-1]) begin
            man_norm = quo[QW-2 -: MW];
            exp_norm = exp_diff;
        end else begin
            man_norm = quo[QW-3 -: MW];
            exp_norm = exp_diff - fp_exp_wide_t'(1);
        end
    end

    always_comb begin
        res.sign     = fa.sign ^ fb.sign;
        res.exponent = exp_norm[`FP_EXP_BITS-1:0];
        res.mantissa = man_norm;
        if (a_zero || (!b_zero && exp_norm <= 0)) begin
            // zero dividend wins over a zero divisor
            res.exponent = '0;
            res.mantissa = '0;
        end else if (b_zero || exp_norm >= fp_exp_wide_t'(FP_EXP_MAX)) begin
            // divide by zero or overflow
            res.exponent = FP_EXP_MAX;
            res.mantissa = '0;
        end
    end

    assign quotient = res;

endmodule

/* hdl/fp_exp_top.sv */
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_exp_top import fp_types_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic [`FP_WIDTH-1:0] x_value,
    output logic                 out_valid,
    output logic [`FP_WIDTH-1:0] result
);

    logic     x_valid_q;
    fp_word_t x_q;
    fp_word_t core_result;

    // input stage, operand loads only with a valid strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_valid_q <= 1'b0;
            x_q       <= '0;
        end else begin
            x_valid_q <= in_valid;
            if (in_valid) begin
                x_q <= x_value;
            end
        end
    end

    // whole series evaluated in one cycle
    exp_taylor u_exp_taylor (
        .x_value (x_q),
        .result  (core_result)
    );

    // output stage, one cycle behind the input stage
    // out_valid is a single cycle pulse per operand
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= x_valid_q;
            if (x_valid_q) begin
                result <= core_result;
            end
        end
    end

endmodule

/* hdl/fp_mul.sv */
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_mul import fp_types_pkg::*; (
    input  fp_word_t a,
    input  fp_word_t b,
    output fp_word_t product
);

    localparam int MW = `FP_MAN_BITS;

    fp_fields_t      fa;
    fp_fields_t      fb;
    fp_fields_t      res;
    logic [MW:0]     ma;
    logic [MW:0]     mb;
    logic [2*MW+1:0] mprod;
    logic [MW-1:0]   man_norm;
    fp_exp_wide_t    exp_sum;
    fp_exp_wide_t    exp_norm;
    logic            any_zero;

    assign fa = a;
    assign fb = b;

    // zero exponent covers both zero and flushed denormals
    assign any_zero = (fa.exponent == '0) || (fb.exponent == '0);

    // mantissas with the hidden bit
    assign ma    = {1'b1, fa.mantissa};
    assign mb    = {1'b1, fb.mantissa};
    assign mprod = ma * mb;

    // biased exponents add, one bias taken back out
    assign exp_sum = fp_exp_wide_t'(fa.exponent) + fp_exp_wide_t'(fb.exponent)
                   - fp_exp_wide_t'(FP_BIAS);

    // product of two values in [1,2) lies in [1,4)
    // at most one bit of normalisation needed
    always_comb begin
        if (mprod[2*MW+1]) begin
            man_norm = mprod[2*MW -: MW];
            exp_norm = exp_sum + fp_exp_wide_t'(1);
        end else begin
            man_norm = mprod[2*MW-1 -: MW];
            exp_norm = exp_sum;
        end
    end

    always_comb begin
        res.sign     = fa.sign ^ fb.sign;
        res.exponent = exp_norm[`FP_EXP_BITS-1:0];
        res.mantissa = man_norm;
        if (any_zero || exp_norm <= 0) begin
            // zero operand or underflow
            res.exponent = '0;
            res.mantissa = '0;
        end else if (exp_norm >= fp_exp_wide_t'(FP_EXP_MAX)) begin
            // saturate to infinity
            res.exponent = FP_EXP_MAX;
            res.mantissa = '0;
        end
    end

    assign product = res;

endmodule

/* hdl/fp_types_pkg.sv */
`include "fp_cfg.svh"

package fp_types_pkg;

    // one float as a raw word
    typedef logic [`FP_WIDTH-1:0] fp_word_t;

    // field view of a word, msb first as in ieee-754
    typedef struct packed {
        logic                    sign;
        logic [`FP_EXP_BITS-1:0] exponent;
        logic [`FP_MAN_BITS-1:0] mantissa;
    } fp_fields_t;

    // exponent with two extra bits
    // room for the carry of a sum and for a negative underflow value
    typedef logic signed [`FP_EXP_BITS+1:0] fp_exp_wide_t;

    // 127 for an 8 bit exponent
    localparam int FP_BIAS = (1 << (`FP_EXP_BITS - 1)) - 1;

    // all ones exponent, infinity when the mantissa is zero
    // nan encodings share it but are not decoded by the units
    localparam logic [`FP_EXP_BITS-1:0] FP_EXP_MAX = '1;

endpackage

/* list.f */
+incdir+hdl
hdl/fp_types_pkg.sv
hdl/exp_series_pkg.sv
hdl/fp_add.sv
hdl/fp_mul.sv
hdl/fp_div.sv
hdl/exp_taylor.sv
hdl/fp_exp_top.sv
testbench/tb_fp_exp.sv

/* testbench/tb_fp_exp.sv */
`timescale 1ns/1ps
`include "fp_cfg.svh"

module tb_fp_exp import fp_types_pkg::*; ();

    localparam int    EW           = `FP_EXP_BITS;
    localparam int    MW           = `FP_MAN_BITS;
    localparam int    RESET_CYCLES = 2;
    localparam int    NUM_BURST    = 24;
    localparam int    NUM_GAPPED   = 24;
    localparam int    DRAIN_LIMIT  = 20;
    localparam real   REL_TOL      = 1.0e-5;
    // ieee-754 single precision 1.0
    localparam fp_word_t ONE_BITS  = 32'h3F80_0000;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    fp_word_t x_value;
    logic     out_valid;
    fp_word_t result;

    integer   seed;
    // rising edges seen so far
    int       edge_count = 0;
    int       sent_total = 0;
    int       checked    = 0;
    // operands in flight and the edge their result is due after
    fp_word_t sent_q [$];
    int       due_q  [$];

    fp_exp_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .x_value   (x_value),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    task automatic stop_on_error();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    // raw float word to real, zero exponent read as zero
    function automatic real bits_to_real(input fp_word_t w);
        fp_fields_t f;
        real        mag;
        int         e;
        f = w;
        if (f.exponent == '0) begin
            return 0.0;
        end
        mag = 1.0 + $itor(f.mantissa) / $itor(1 << MW);
        e   = int'(f.exponent) - FP_BIAS;
        while (e > 0) begin
            mag = mag * 2.0;
            e--;
        end
        while (e < 0) begin
            mag = mag / 2.0;
            e++;
        end
        return f.sign ? -mag : mag;
    endfunction

    // truncated series 1 + |x| + |x|^2/2! + ... on |x|
    // reciprocal of the sum for negative x
    function automatic real ref_exp(input real x);
        real ax;
        real term;
        real sum;
        ax   = (x < 0.0) ? -x : x;
        term = 1.0;
        sum  = 1.0;
        for (int k = 1; k <= `EXP_TERMS; k++) begin
            term = term * ax / k;
            sum  = sum + term;
        end
        return (x < 0.0) ? 1.0 / sum : sum;
    endfunction

    function automatic bit close_enough(input real got, input real want);
        real diff;
        real mag;
        diff = got - want;
        if (diff < 0.0) begin
            diff = -diff;
        end
        mag = (want < 0.0) ? -want : want;
        return diff <= REL_TOL * mag;
    endfunction

    // magnitude in [2^-10, 1), sign as asked
    function automatic fp_word_t random_operand(input logic negative);
        fp_fields_t f;
        int         r;
        int         m;
        r          = $random(seed);
        m          = $random(seed);
        f.sign     = negative;
        f.exponent = EW'(FP_BIAS - 1 - ((r & 32'h7fff_ffff) % 10));
        f.mantissa = MW'(m);
        return f;
    endfunction

    // one operand, captured at the next rising edge
    task automatic drive_operand(input fp_word_t x);
        @(negedge clk);
        in_valid = 1'b1;
        x_value  = x;
        sent_q.push_back(x);
        // capture edge is edge_count+1, result valid after the one after
        due_q.push_back(edge_count + 2);
        sent_total++;
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            in_valid = 1'b0;
            x_value  = '0;
        end
    endtask

    // compare side, sampled on the falling edge where outputs are settled
    initial begin : compare_results
        fp_word_t x_sent;
        int       due;
        real      got;
        real      want;
        forever begin
            @(negedge clk);
            if (out_valid) begin
                assert (sent_q.size() > 0) else begin
                    $display("out_valid went high with no operand outstanding at %0t", $time);
                    stop_on_error();
                end
                x_sent = sent_q.pop_front();
                due    = due_q.pop_front();
                // latency of exactly two edges, order kept
                assert (edge_count == due) else begin
                    $display("[FAIL] %0t out_valid edge: got %0d expected %0d",
                             $time, edge_count, due);
                    stop_on_error();
                end
                if (x_sent[MW+EW-1:0] == '0) begin
                    // +0 and -0 give the exact 1.0 pattern
                    assert (result == ONE_BITS) else begin
                        $display("[FAIL] %0t result for x=%h: got %h expected %h",
                                 $time, x_sent, result, ONE_BITS);
                        stop_on_error();
                    end
                end else begin
                    got  = bits_to_real(result);
                    want = ref_exp(bits_to_real(x_sent));
                    assert (close_enough(got, want)) else begin
                        $display("[FAIL] %0t result for x=%h: got %h (%g) expected %g",
                                 $time, x_sent, result, got, want);
                        stop_on_error();
                    end
                end
                checked++;
            end
        end
    end

    initial begin : stimulus
        int r;
        int wait_cycles;
        seed     = 52734;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        x_value  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // quiet output until the first operand
        repeat (3) begin
            @(negedge clk);
            assert (out_valid == 1'b0) else begin
                $display("[FAIL] %0t out_valid: got %b expected 0", $time, out_valid);
                stop_on_error();
            end
        end

        // signed zeros and the ends of the range
        drive_operand(32'h0000_0000);
        drive_operand(32'h8000_0000);
        drive_operand(32'h3F80_0000);
        drive_operand(32'hBF80_0000);
        drive_idle(3);

        // back to back positive, then back to back negative
        for (int k = 0; k < NUM_BURST; k++) begin
            drive_operand(random_operand(1'b0));
        end
        drive_idle(2);
        for (int k = 0; k < NUM_BURST; k++) begin
            drive_operand(random_operand(1'b1));
        end
        drive_idle(1);

        // mixed signs with random holes in in_valid
        for (int k = 0; k < NUM_GAPPED; k++) begin
            r = $random(seed);
            drive_operand(random_operand(r[0]));
            if (r[4]) begin
                drive_idle(1 + int'(r[3:2]));
            end
        end
        drive_idle(1);

        // wait for the pipeline to empty
        wait_cycles = 0;
        while (sent_q.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            wait_cycles++;
        end
        // a few more cycles to catch a stray out_valid
        drive_idle(3);

        if (sent_q.size() == 0 && checked == sent_total) begin
            $display("%0d results checked", checked);
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("timed out with %0d of %0d results never seen",
                     sent_total - checked, sent_total);
            stop_on_error();
        end
    end

endmodule
